// File: verilog/rv_pkg.sv
package rv_pkg;

  typedef logic [31:0] word_t;    // data or address word
  typedef logic [4:0]  reg_idx_t; // register index x0..x31
  typedef logic [6:0]  opcode_t;  // major opcode, instr[6:0]
  typedef logic [2:0]  funct3_t;  // minor opcode, instr[14:12]
  typedef logic [1:0]  size_t;    // store_size code on the data port

  // major opcodes of the base integer set
  localparam opcode_t op_lui    = 7'b0110111;
  localparam opcode_t op_auipc  = 7'b0010111;
  localparam opcode_t op_jal    = 7'b1101111;
  localparam opcode_t op_jalr   = 7'b1100111;
  localparam opcode_t op_branch = 7'b1100011;
  localparam opcode_t op_load   = 7'b0000011;
  localparam opcode_t op_store  = 7'b0100011;
  localparam opcode_t op_imm    = 7'b0010011;
  localparam opcode_t op_reg    = 7'b0110011;

  // store_size encodings, 11 means the port reads
  localparam size_t sz_byte = 2'b00;
  localparam size_t sz_half = 2'b01;
  localparam size_t sz_word = 2'b10;
  localparam size_t sz_read = 2'b11;

  // writeback source select
  localparam logic [1:0] wd_alu = 2'b00; // alu result
  localparam logic [1:0] wd_mem = 2'b01; // extended load data
  localparam logic [1:0] wd_pc4 = 2'b10; // link address
  localparam logic [1:0] wd_imm = 2'b11; // upper immediate for lui

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  typedef enum logic [1:0] {
    s_fetch, // latch instruction
    s_exec,  // alu, branch decision, most writebacks
    s_mem,   // data port access, stretched by stall_mem
    s_wb     // load writeback
  } ctrl_state_e;

endpackage

// File: verilog/decode.sv
module decode import rv_pkg::*; (
  input  word_t    instr,
  output opcode_t  op,
  output funct3_t  funct3,
  output logic     funct7_b5,
  output reg_idx_t rd,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output word_t    imm
);

  // fixed field positions, same for every format
  assign op        = instr[6:0];
  assign rd        = instr[11:7];
  assign funct3    = instr[14:12];
  assign rs1       = instr[19:15];
  assign rs2       = instr[24:20];
  assign funct7_b5 = instr[30]; // sub / sra select

  // immediate per format, sign always from instr[31]
  always_comb begin
    case (op)
      op_store: begin // S
        imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
      end
      op_branch: begin // B, bit 0 implied zero
        imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      op_lui, op_auipc: begin // U
        imm = {instr[31:12], 12'b0};
      end
      op_jal: begin // J
        imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: begin
        // I format covers jalr, loads and alu immediates
        imm = {{21{instr[31]}}, instr[30:20]};
      end
    endcase
  end

endmodule

// File: verilog/controller.sv
module controller import rv_pkg::*; (
  input  logic        CLK,
  input  logic        rst_n,
  input  opcode_t     op,
  input  funct3_t     funct3,
  input  logic        funct7_b5,
  input  logic        branch_taken,
  input  logic        stall_mem,
  output logic        ir_load,
  output logic        reg_we,
  output logic        pc_load,
  output logic        memory_en,
  output logic        alu_b_sel,
  output logic        retire,
  output logic        pc_target_sel,
  output logic [1:0]  wd_sel,
  output alu_op_e     alu_op,
  output size_t       store_size
);

  ctrl_state_e state, state_nxt;

  logic is_mem;  // load or store, goes through s_mem
  logic writes;  // non-memory instruction with a destination register

  assign is_mem = (op == op_load) || (op == op_store);
  assign writes = (op == op_lui) || (op == op_auipc) || (op == op_jal) ||
                  (op == op_jalr) || (op == op_imm) || (op == op_reg);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state <= s_fetch;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      s_fetch: state_nxt = s_exec;
      s_exec:  state_nxt = is_mem ? s_mem : s_fetch;
      s_mem: begin
        if (!stall_mem) begin // access done this cycle
          state_nxt = (op == op_load) ? s_wb : s_fetch;
        end
      end
      default: state_nxt = s_fetch; // s_wb
    endcase
  end

  // enables per state
  always_comb begin
    ir_load = 1'b0;
    reg_we  = 1'b0;
    pc_load = 1'b0;
    retire  = 1'b0;
    case (state)
      s_fetch: ir_load = 1'b1;
      s_exec: begin
        if (!is_mem) begin // unknown opcodes retire as no-ops
          reg_we  = writes;
          pc_load = 1'b1;
          retire  = 1'b1;
        end
      end
      s_mem: begin
        if (!stall_mem && op == op_store) begin
          pc_load = 1'b1;
          retire  = 1'b1;
        end
      end
      default: begin // s_wb, load result goes in
        reg_we  = 1'b1;
        pc_load = 1'b1;
        retire  = 1'b1;
      end
    endcase
  end

  assign memory_en  = (state == s_mem);
  assign store_size = (state == s_mem && op == op_store) ? size_t'(funct3[1:0]) : sz_read;

  // target only for taken branches and jumps, else pc + 4
  assign pc_target_sel = (op == op_jal) || (op == op_jalr) ||
                         ((op == op_branch) && branch_taken);

  assign alu_b_sel = (op != op_reg) && (op != op_branch); // imm operand

  always_comb begin
    case (op)
      op_lui:          wd_sel = wd_imm;
      op_jal, op_jalr: wd_sel = wd_pc4;
      op_load:         wd_sel = wd_mem;
      default:         wd_sel = wd_alu;
    endcase
  end

  // alu operation from funct3, funct7 bit 5 only for sub and sra
  always_comb begin
    alu_op = alu_add; // address and target math
    if (op == op_reg || op == op_imm) begin
      case (funct3)
        3'b000:  alu_op = (op == op_reg && funct7_b5) ? alu_sub : alu_add;
        3'b001:  alu_op = alu_sll;
        3'b010:  alu_op = alu_slt;
        3'b011:  alu_op = alu_sltu;
        3'b100:  alu_op = alu_xor;
        3'b101:  alu_op = funct7_b5 ? alu_sra : alu_srl;
        3'b110:  alu_op = alu_or;
        default: alu_op = alu_and;
      endcase
    end
  end

endmodule

// File: verilog/pc_unit.sv
module pc_unit import rv_pkg::*; #(
  parameter word_t RESET_VECTOR = 32'h0000_0000
) (
  input  logic  CLK,
  input  logic  rst_n,
  input  logic  pc_load,
  input  logic  pc_target_sel,
  input  word_t target,
  output word_t pc,
  output word_t pc_plus4
);

  assign pc_plus4 = pc + 32'd4; // sequential step, also the link value

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      pc <= RESET_VECTOR;
    end else if (pc_load) begin
      if (pc_target_sel) begin
        pc <= {target[31:1], 1'b0}; // jalr may produce an odd target
      end else begin
        pc <= pc_plus4;
      end
    end
  end

endmodule

// File: verilog/regfile.sv
module regfile import rv_pkg::*; (
  input  logic     CLK,
  input  logic     we,
  input  reg_idx_t wa,
  input  reg_idx_t ra1,
  input  reg_idx_t ra2,
  input  word_t    wd,
  output word_t    rd1,
  output word_t    rd2
);

  word_t regs [32]; // entry 0 never written

  always_ff @(posedge CLK) begin
    if (we && wa != 5'd0) begin // writes to x0 dropped
      regs[wa] <= wd;
    end
  end

  // combinational reads, x0 forced to zero
  assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
  assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

endmodule

// File: verilog/alu.sv
module alu import rv_pkg::*; (
  input  word_t   a,
  input  word_t   b,
  input  alu_op_e alu_op,
  input  funct3_t funct3,
  output word_t   result,
  output logic    branch_taken
);

  logic [4:0] shamt;
  logic       lt_s; // signed a < b
  logic       lt_u; // unsigned a < b

  assign shamt = b[4:0]; // only low five bits shift
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb begin
    case (alu_op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_sll:  result = a << shamt;
      alu_slt:  result = {31'd0, lt_s};
      alu_sltu: result = {31'd0, lt_u};
      alu_xor:  result = a ^ b;
      alu_srl:  result = a >> shamt;
      alu_sra:  result = word_t'($signed(a) >>> shamt);
      alu_or:   result = a | b;
      default:  result = a & b; // alu_and
    endcase
  end

  // branch condition on rs1 / rs2, funct3 of the branch
  always_comb begin
    case (funct3)
      3'b000:  branch_taken = (a == b); // beq
      3'b001:  branch_taken = (a != b); // bne
      3'b100:  branch_taken = lt_s;     // blt
      3'b101:  branch_taken = !lt_s;    // bge
      3'b110:  branch_taken = lt_u;     // bltu
      3'b111:  branch_taken = !lt_u;    // bgeu
      default: branch_taken = 1'b0;     // reserved encodings fall through
    endcase
  end

endmodule

// File: verilog/load_store.sv
module load_store import rv_pkg::*; (
  input  logic    CLK,
  input  funct3_t funct3,
  input  logic    load_capture,
  input  word_t   rd2,
  input  word_t   mem_read_data,
  output word_t   load_data,
  output word_t   mem_write_data
);

  word_t read_q; // raw read word, held for s_wb

  always_ff @(posedge CLK) begin
    if (load_capture) begin
      read_q <= mem_read_data; // addressed bytes already in the low bits
    end
  end

  // extend by load width, funct3[2] means unsigned
  always_comb begin
    case (funct3)
      3'b000:  load_data = {{24{read_q[7]}}, read_q[7:0]};   // lb
      3'b001:  load_data = {{16{read_q[15]}}, read_q[15:0]}; // lh
      3'b100:  load_data = {24'd0, read_q[7:0]};             // lbu
      3'b101:  load_data = {16'd0, read_q[15:0]};            // lhu
      default: load_data = read_q;                           // lw
    endcase
  end

  // store data cut to size, upper bytes zero
  always_comb begin
    case (size_t'(funct3[1:0]))
      sz_byte: mem_write_data = {24'd0, rd2[7:0]};
      sz_half: mem_write_data = {16'd0, rd2[15:0]};
      sz_word: mem_write_data = rd2;
      default: mem_write_data = rd2; // not a valid store width
    endcase
  end

endmodule

// File: verilog/core.sv
module core import rv_pkg::*; #(
  parameter word_t RESET_VECTOR = 32'h0000_0000
) (
  input  logic  CLK,
  input  logic  rst_n,
  output word_t instr_addr,
  input  word_t instr_fetch,
  output logic  memory_en,
  output size_t store_size,
  output word_t mem_addr,
  output word_t mem_write_data,
  input  word_t mem_read_data,
  input  logic  stall_mem,
  output logic  retire
);

  word_t    ir;               // instruction register
  opcode_t  op;
  funct3_t  funct3;
  logic     funct7_b5;
  reg_idx_t rd, rs1, rs2;
  word_t    imm, rd1, rd2;
  word_t    pc, pc_plus4, pc_target, branch_target;
  word_t    alu_a, alu_b, alu_result, load_data, wd;
  alu_op_e  alu_op;
  logic     ir_load, reg_we, pc_load, alu_b_sel, pc_target_sel, branch_taken;
  logic     load_capture;
  logic [1:0] wd_sel;

  always_ff @(posedge CLK) begin
    if (ir_load) begin
      ir <= instr_fetch; // fetch is combinational on instr_addr
    end
  end

  decode u_decode (
    .instr(ir), .op(op), .funct3(funct3), .funct7_b5(funct7_b5),
    .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm)
  );

  controller u_controller (
    .CLK(CLK), .rst_n(rst_n), .op(op), .funct3(funct3), .funct7_b5(funct7_b5),
    .branch_taken(branch_taken), .stall_mem(stall_mem), .ir_load(ir_load),
    .reg_we(reg_we), .pc_load(pc_load), .memory_en(memory_en),
    .alu_b_sel(alu_b_sel), .retire(retire), .pc_target_sel(pc_target_sel),
    .wd_sel(wd_sel), .alu_op(alu_op), .store_size(store_size)
  );

  pc_unit #(.RESET_VECTOR(RESET_VECTOR)) u_pc_unit (
    .CLK(CLK), .rst_n(rst_n), .pc_load(pc_load), .pc_target_sel(pc_target_sel),
    .target(pc_target), .pc(pc), .pc_plus4(pc_plus4)
  );

  regfile u_regfile (
    .CLK(CLK), .we(reg_we), .wa(rd), .ra1(rs1), .ra2(rs2), .wd(wd),
    .rd1(rd1), .rd2(rd2)
  );

  // operand a is pc for auipc and jal, rs1 otherwise
  assign alu_a = (op == op_auipc || op == op_jal) ? pc : rd1;
  assign alu_b = alu_b_sel ? imm : rd2;

  alu u_alu (
    .a(alu_a), .b(alu_b), .alu_op(alu_op), .funct3(funct3),
    .result(alu_result), .branch_taken(branch_taken)
  );

  // branches compare rs1 and rs2 in the alu, so the offset add sits here
  assign branch_target = pc + imm;
  assign pc_target     = (op == op_branch) ? branch_target : alu_result;

  assign instr_addr   = pc;
  assign mem_addr     = alu_result;             // rs1 + offset during s_mem
  assign load_capture = memory_en & ~stall_mem; // completing cycle of the access

  load_store u_load_store (
    .CLK(CLK), .funct3(funct3), .load_capture(load_capture), .rd2(rd2),
    .mem_read_data(mem_read_data), .load_data(load_data),
    .mem_write_data(mem_write_data)
  );

  always_comb begin
    case (wd_sel)
      wd_mem:  wd = load_data;
      wd_pc4:  wd = pc_plus4; // pc not yet updated when the link is written
      wd_imm:  wd = imm;
      default: wd = alu_result;
    endcase
  end

endmodule

// File: verification/rv_ref_model.sv
package rv_ref_model;

  // architectural state of the reference core
  logic [31:0] ref_regs [32];
  logic [31:0] ref_pc;
  logic [7:0]  ref_mem [4096]; // data space, wraps on addr[11:0]

  // instruction encoders, fields in ISA order
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  function automatic void ref_reset(input logic [31:0] vector);
    foreach (ref_regs[i]) ref_regs[i] = 32'd0;
    ref_pc = vector;
  endfunction

  // integer ops straight from the ISA table, alt selects sub / sra
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] x, input logic [31:0] y);
    case (f3)
      3'd0:    return alt ? x - y : x + y;
      3'd1:    return x << y[4:0];
      3'd2:    return {31'd0, $signed(x) < $signed(y)};
      3'd3:    return {31'd0, x < y};
      3'd4:    return x ^ y;
      3'd5:    return alt ? 32'($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'd6:    return x | y;
      default: return x & y;
    endcase
  endfunction

  // one instruction, reports the store it should make
  function automatic void ref_step(input logic [31:0] instr, output logic st_en,
                                   output logic [31:0] st_addr, output logic [1:0] st_size,
                                   output logic [31:0] st_data);
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [31:0] a, b, imm_i, imm_s, imm_b, imm_j, nxt, res, adr, w;
    logic        wr;
    rd    = instr[11:7];
    rs1   = instr[19:15];
    rs2   = instr[24:20];
    f3    = instr[14:12];
    a     = ref_regs[rs1];
    b     = ref_regs[rs2];
    imm_i = {{20{instr[31]}}, instr[31:20]};
    imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    nxt     = ref_pc + 32'd4;
    res     = 32'd0;
    wr      = 1'b0;
    st_en   = 1'b0;
    st_addr = 32'd0;
    st_size = 2'b11;
    st_data = 32'd0;
    case (instr[6:0])
      7'h37: begin res = {instr[31:12], 12'd0}; wr = 1'b1; end
      7'h17: begin res = ref_pc + {instr[31:12], 12'd0}; wr = 1'b1; end
      7'h6f: begin res = nxt; wr = 1'b1; nxt = ref_pc + imm_j; end
      7'h67: begin
        res = nxt; // link, target taken from rs1 before the write
        wr  = 1'b1;
        nxt = (a + imm_i) & ~32'd1;
      end
      7'h63: begin
        case (f3)
          3'd0: if (a == b) nxt = ref_pc + imm_b;
          3'd1: if (a != b) nxt = ref_pc + imm_b;
          3'd4: if ($signed(a) < $signed(b)) nxt = ref_pc + imm_b;
          3'd5: if ($signed(a) >= $signed(b)) nxt = ref_pc + imm_b;
          3'd6: if (a < b) nxt = ref_pc + imm_b;
          3'd7: if (a >= b) nxt = ref_pc + imm_b;
          default: ;
        endcase
      end
      7'h03: begin
        adr = a + imm_i;
        w = {ref_mem[12'(adr + 3)], ref_mem[12'(adr + 2)],
             ref_mem[12'(adr + 1)], ref_mem[adr[11:0]]};
        case (f3)
          3'd0:    res = {{24{w[7]}}, w[7:0]};
          3'd1:    res = {{16{w[15]}}, w[15:0]};
          3'd4:    res = {24'd0, w[7:0]};
          3'd5:    res = {16'd0, w[15:0]};
          default: res = w;
        endcase
        wr = 1'b1;
      end
      7'h23: begin
        st_en   = 1'b1;
        st_addr = a + imm_s;
        st_size = f3[1:0];
        st_data = (f3[1:0] == 2'b00) ? {24'd0, b[7:0]} :
                  (f3[1:0] == 2'b01) ? {16'd0, b[15:0]} : b;
        ref_mem[st_addr[11:0]] = b[7:0];
        if (f3[1:0] != 2'b00) ref_mem[12'(st_addr + 1)] = b[15:8];
        if (f3[1:0] == 2'b10) begin
          ref_mem[12'(st_addr + 2)] = b[23:16];
          ref_mem[12'(st_addr + 3)] = b[31:24];
        end
      end
      7'h13: begin res = alu_ref(f3, (f3 == 3'd5) && instr[30], a, imm_i); wr = 1'b1; end
      7'h33: begin res = alu_ref(f3, instr[30], a, b); wr = 1'b1; end
      default: ; // fence, system: no-op
    endcase
    if (wr && rd != 5'd0) ref_regs[rd] = res;
    ref_pc = nxt;
  endfunction

endpackage

// File: verification/core_tb.sv
module core_tb import rv_ref_model::*; ;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] RESET_VECTOR = 32'h0000_0000;
  localparam int          PERIOD       = 40;

  logic        CLK, rst_n, memory_en, stall_mem, retire;
  logic [31:0] instr_addr, instr_fetch, mem_addr, mem_write_data, mem_read_data;
  logic [1:0]  store_size;

  logic [31:0] imem [256];  // program memory by word index
  logic [7:0]  dmem [4096]; // data space seen by the DUT
  logic [31:0] rng;
  logic [31:0] end_addr;
  int          prog_len, slot, stall_left;
  logic        done, pending_pc, prev_en, prev_stall, started;

  core #(.RESET_VECTOR(RESET_VECTOR)) uut (
    .CLK(CLK), .rst_n(rst_n), .instr_addr(instr_addr), .instr_fetch(instr_fetch),
    .memory_en(memory_en), .store_size(store_size), .mem_addr(mem_addr),
    .mem_write_data(mem_write_data), .mem_read_data(mem_read_data),
    .stall_mem(stall_mem), .retire(retire)
  );

  always #(PERIOD / 2) CLK = ~CLK;

  // combinational reads with the addressed bytes in the low bits
  assign instr_fetch   = imem[instr_addr[9:2]];
  assign mem_read_data = {dmem[12'(mem_addr + 3)], dmem[12'(mem_addr + 2)],
                          dmem[12'(mem_addr + 1)], dmem[mem_addr[11:0]]};

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic logic [7:0] fill_byte(input logic [11:0] a);
    return 8'h80 | (a[7:0] * 8'd13) ^ {a[11:8], a[11:8]}; // top bit always set
  endfunction

  function logic [4:0] pick_reg();
    return 5'(1 + next_rand() % 15); // x1..x15
  endfunction

  task automatic emit(input logic [31:0] w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  // sw, sh or sb of a register into the next result slot
  task automatic emit_store(input logic [4:0] rs);
    emit(enc_s(12'(12'h500 + (slot % 64) * 4), rs, 5'd0, 3'(next_rand() % 3)));
    slot++;
  endtask

  task automatic build_program();
    logic [4:0]  rd, r1, r2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [2:0]  ld_f3 [5];
    logic [2:0]  br_f3 [6];
    ld_f3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    emit_store(5'd0); // x0 must store as zero
    for (int r = 1; r < 16; r++) begin
      emit(enc_u(20'(next_rand()), 5'(r), 7'h37));
      emit(enc_i(12'(next_rand()), 5'(r), 3'd0, 5'(r), 7'h13));
    end
    for (int i = 0; i < 40; i++) begin
      rd = pick_reg();
      r1 = pick_reg();
      r2 = pick_reg();
      f3 = 3'(next_rand());
      case (next_rand() % 10)
        0, 1, 2: begin // register ops with sub / sra picked by bit 30
          emit(enc_r((f3 == 3'd0 || f3 == 3'd5) ? {1'b0, 1'(next_rand()), 5'd0} : 7'd0,
                     r2, r1, f3, rd, 7'h33));
        end
        3, 4: begin
          imm = 12'(next_rand());
          if (f3 == 3'd1) imm = {7'd0, imm[4:0]};                 // slli
          if (f3 == 3'd5) imm = {1'b0, imm[10], 5'd0, imm[4:0]};  // srli / srai
          emit(enc_i(imm, r1, f3, rd, 7'h13));
        end
        5: begin
          f3 = ld_f3[next_rand() % 5];
          imm = 12'(12'h400 + (next_rand() % 16) & ~((32'd1 << f3[1:0]) - 1));
          emit(enc_i(imm, 5'd0, f3, rd, 7'h03));
        end
        6: begin // forward branch over one addi
          emit(enc_b(13'd8, r2, r1, br_f3[next_rand() % 6]));
          emit(enc_i(12'(next_rand()), rd, 3'd0, rd, 7'h13));
        end
        7: begin
          if (next_rand() % 2 == 0) begin
            emit(enc_j(21'd8, rd));
          end else begin
            emit(enc_u(20'd0, 5'd14, 7'h17));           // auipc x14, 0
            emit(enc_i(12'd13, 5'd14, 3'd0, rd, 7'h67)); // odd target lands past the skip
          end
          emit(enc_i(12'h7ff, rd, 3'd0, rd, 7'h13)); // skipped
        end
        8:       emit(enc_u(20'(next_rand()), rd, 7'h37));
        default: emit(enc_u(20'(next_rand()), rd, 7'h17));
      endcase
      emit_store(rd);
    end
    end_addr = RESET_VECTOR + 32'(prog_len * 4);
    emit(enc_j(21'd0, 5'd0)); // final loop
  endtask

  task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("[ERROR] %s got %08h expected %08h", name, got, exp);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic fail_text(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1);
  endtask

  // memory model draws a new 0..3 stall budget after each completed access
  always @(posedge CLK) begin
    if (!rst_n) begin
      stall_left <= 2;
      stall_mem  <= 1'b1;
    end else if (memory_en && stall_mem) begin
      stall_left <= stall_left - 1;
      if (stall_left <= 1) stall_mem <= 1'b0;
    end else if (memory_en) begin
      if (store_size != 2'b11) begin
        dmem[mem_addr[11:0]] <= mem_write_data[7:0];
        if (store_size != 2'b00) dmem[12'(mem_addr + 1)] <= mem_write_data[15:8];
        if (store_size == 2'b10) begin
          dmem[12'(mem_addr + 2)] <= mem_write_data[23:16];
          dmem[12'(mem_addr + 3)] <= mem_write_data[31:24];
        end
      end
      stall_left <= int'(next_rand() % 4);
      stall_mem  <= (rng % 4) != 0;
    end
  end

  // comparison against the reference at mid-cycle
  always @(negedge CLK) begin
    logic        st_en;
    logic [31:0] st_addr, st_data;
    logic [1:0]  st_size;
    if (rst_n && started) begin
      if (pending_pc) begin
        assert (instr_addr === ref_pc) else fail_value("instr_addr", instr_addr, ref_pc);
        pending_pc = 1'b0;
        if (ref_pc == end_addr) done = 1'b1;
      end
      assert (!(prev_en && !prev_stall && memory_en))
        else fail_text("memory_en stayed high after the access completed");
      assert (!(prev_en && prev_stall && !memory_en))
        else fail_text("memory_en dropped while stall_mem was high");
      if (retire) begin
        ref_step(imem[ref_pc[9:2]], st_en, st_addr, st_size, st_data);
        if (st_en) begin
          assert (memory_en === 1'b1) else fail_value("memory_en", 32'(memory_en), 32'd1);
          assert (mem_addr === st_addr) else fail_value("mem_addr", mem_addr, st_addr);
          assert (store_size === st_size)
            else fail_value("store_size", 32'(store_size), 32'(st_size));
          assert (mem_write_data === st_data)
            else fail_value("mem_write_data", mem_write_data, st_data);
        end else begin
          assert (store_size === 2'b11) else fail_value("store_size", 32'(store_size), 32'd3);
        end
        pending_pc = 1'b1;
      end
      prev_en    = memory_en;
      prev_stall = stall_mem;
    end
  end

  // watchdog allows 8 cycles per instruction plus up to 3 stall cycles each
  initial begin
    wait (prog_len > 0 && started);
    #(PERIOD * (prog_len * 11 + 16));
    fail_text("watchdog expired before the program reached its final loop");
  end

  initial begin
    CLK         = 1'b0;
    rst_n       = 1'b0;
    stall_mem   = 1'b0;
    rng         = 32'd52;
    prog_len    = 0;
    slot        = 0;
    done        = 1'b0;
    pending_pc  = 1'b0;
    prev_en     = 1'b0;
    prev_stall  = 1'b0;
    started     = 1'b0;
    foreach (imem[i]) imem[i] = enc_i(12'(i), 5'd0, 3'd0, 5'd0, 7'h13); // nop tagged by index
    for (int a = 0; a < 4096; a++) begin
      dmem[a]    = fill_byte(12'(a));
      ref_mem[a] = fill_byte(12'(a));
    end
    build_program();
    ref_reset(RESET_VECTOR);
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    assert (instr_addr === RESET_VECTOR) else fail_value("instr_addr", instr_addr, RESET_VECTOR);
    assert (memory_en === 1'b0) else fail_value("memory_en", 32'(memory_en), 32'd0);
    assert (store_size === 2'b11) else fail_value("store_size", 32'(store_size), 32'd3);
    assert (retire === 1'b0) else fail_value("retire", 32'(retire), 32'd0);
    repeat (6) @(posedge CLK);
    rst_n   <= 1'b1;
    started = 1'b1;
    wait (done);
    @(posedge CLK);
    $display("Done: no errors");
    $finish;
  end

endmodule

// File: vlog.f
verilog/rv_pkg.sv
verilog/decode.sv
verilog/controller.sv
verilog/pc_unit.sv
verilog/regfile.sv
verilog/alu.sv
verilog/load_store.sv
verilog/core.sv
verification/rv_ref_model.sv
verification/core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
RTL_TOP   ?= core
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
FAIL_MSG  := Done: errors found
PASS_MSG  := Done: no errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
